// File: dram_defines.svh
`ifndef DRAM_DEFINES_SVH
`define DRAM_DEFINES_SVH

// Arbiter byte address and the x8 field split
`define ADDR_W    32
`define OFFSET_W  3
`define COL_W     7
`define BANK_W    2
`define BG_W      2
`define ROW_W     15
`define RANK_W    1

// Counter widths for the per-state and refresh counters
`define CNT_W     4
`define REFI_W    8

// Power-up sequence lengths in clock cycles
`define T_INIT    8
`define T_MRS     4
`define T_ZQ      6

// Command timings in clock cycles
`define T_RP      3
`define T_RCD     3
`define T_CL      4
`define T_WR      4
`define T_RFC     6
`define T_REFI    200

`endif

// File: dram_pkg.sv
`include "dram_defines.svh"

package dram_pkg;

    // Init states first, then the command states
    typedef enum logic [3:0] {
        POWER_UP,
        CKE_WAIT,
        MRS_LOAD,
        ZQ_CAL,
        IDLE,
        PRECHARGE,
        ACTIVATE,
        READ,
        WRITE,
        REFRESH
    } dram_state_t;

    typedef enum logic [1:0] {
        ROW_CLOSED   = 2'b00,
        ROW_HIT      = 2'b01,
        ROW_CONFLICT = 2'b11
    } row_stat_t;

    typedef struct packed {
        logic [`RANK_W-1:0]   rank;
        logic [`BG_W-1:0]     bg;
        logic [`BANK_W-1:0]   bank;
        logic [`ROW_W-1:0]    row;
        logic [`COL_W-1:0]    col;
        logic [`OFFSET_W-1:0] offset;
    } dram_addr_t;

    typedef struct packed {
        logic               ren;
        logic               wen;
        logic [`ADDR_W-1:0] addr;
    } arb_req_t;

    // Strobes toward the data-transfer block
    typedef struct packed {
        logic                 wr_en;
        logic                 rd_en;
        logic                 clear;
        logic [`OFFSET_W-1:0] offset;
    } xfer_t;

    // Column here is the column joined with the burst offset
    typedef struct packed {
        dram_state_t                   state;
        dram_state_t                   nstate;
        logic [`RANK_W-1:0]            rank;
        logic [`BG_W-1:0]              bg;
        logic [`BANK_W-1:0]            bank;
        logic [`ROW_W-1:0]             row;
        logic [`COL_W+`OFFSET_W-1:0]   col;
        logic                          rf_req;
    } dram_sig_t;

    typedef struct packed {
        logic act_done;
        logic pre_done;
        logic rd_done;
        logic wr_done;
        logic ref_done;
        logic rf_req;
    } timing_t;

endpackage

// File: addr_mapper.sv
`timescale 1ns/1ps

`include "dram_defines.svh"

module addr_mapper import dram_pkg::*; (
    input  logic [`ADDR_W-1:0] addr,
    output dram_addr_t         amap
);

    // Bit positions of each field, lowest field first
    localparam int COL_LSB  = `OFFSET_W;
    localparam int BANK_LSB = COL_LSB + `COL_W;
    localparam int BG_LSB   = BANK_LSB + `BANK_W;
    localparam int ROW_LSB  = BG_LSB + `BG_W;
    localparam int RANK_LSB = ROW_LSB + `ROW_W;

    // x8 order: offset, column, bank, bank group, row, rank
    // The top two address bits are not mapped
    always_comb begin
        amap.offset = addr[0 +: `OFFSET_W];
        amap.col    = addr[COL_LSB +: `COL_W];
        amap.bank   = addr[BANK_LSB +: `BANK_W];
        amap.bg     = addr[BG_LSB +: `BG_W];
        amap.row    = addr[ROW_LSB +: `ROW_W];
        amap.rank   = addr[RANK_LSB +: `RANK_W];
    end

endmodule

// File: row_open.sv
`timescale 1ns/1ps

`include "dram_defines.svh"

module row_open import dram_pkg::*; (
    input  logic               CLK,
    input  logic               reset,
    input  logic [`BG_W-1:0]   bg,
    input  logic [`BANK_W-1:0] bank,
    input  logic [`ROW_W-1:0]  row,
    input  logic               req_en,
    input  logic               row_resolve,
    input  logic               row_close,
    input  logic               refresh,
    output row_stat_t          row_stat,
    output logic [`ROW_W-1:0]  conflict_row
);

    localparam int NUM_BANKS = 1 << (`BG_W + `BANK_W);

    logic [NUM_BANKS-1:0]                    open_vld;
    logic [NUM_BANKS-1:0][`ROW_W-1:0]        open_row;
    logic [`BG_W+`BANK_W-1:0]                idx;

    assign idx = {bg, bank};

    // Refresh closes every bank at once
    always_ff @(posedge CLK) begin
        if (reset || refresh) begin
            open_vld <= '0;
        end else if (row_resolve) begin
            open_vld[idx] <= 1'b1;
        end else if (row_close) begin
            open_vld[idx] <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (row_resolve) begin
            open_row[idx] <= row;
        end
    end

    always_comb begin
        row_stat = ROW_CLOSED;
        if (req_en && open_vld[idx]) begin
            row_stat = (open_row[idx] == row) ? ROW_HIT : ROW_CONFLICT;
        end
    end

    // Row to precharge, only meaningful on a conflict
    assign conflict_row = (row_stat == ROW_CONFLICT) ? open_row[idx] : '0;

    a_resolve_close_excl: assert property (@(posedge CLK) disable iff (reset)
        !(row_resolve && row_close));

endmodule

// File: init_state.sv
`timescale 1ns/1ps

`include "dram_defines.svh"

module init_state import dram_pkg::*; (
    input  logic        CLK,
    input  logic        reset,
    input  logic        init,
    output logic        init_done,
    output dram_state_t init_st,
    output dram_state_t init_nst
);

    localparam logic [`CNT_W-1:0] INIT_LAST = `T_INIT - 1;
    localparam logic [`CNT_W-1:0] MRS_LAST  = `T_MRS - 1;
    localparam logic [`CNT_W-1:0] ZQ_LAST   = `T_ZQ - 1;

    logic              running;
    logic [`CNT_W-1:0] cnt;
    logic              step;

    // Last cycle of the current power-up step
    assign step = running && (cnt == '0);

    always_comb begin
        init_nst = init_st;
        if (step) begin
            case (init_st)
                POWER_UP: init_nst = CKE_WAIT;
                CKE_WAIT: init_nst = MRS_LOAD;
                MRS_LOAD: init_nst = ZQ_CAL;
                ZQ_CAL:   init_nst = IDLE;
                default:  init_nst = init_st;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            init_st   <= POWER_UP;
            cnt       <= INIT_LAST;
            running   <= 1'b0;
            init_done <= 1'b0;
        end else begin
            init_st <= init_nst;
            // Sequence starts the cycle after the request is seen
            if (init && !init_done && !running) begin
                running <= 1'b1;
            end
            if (step) begin
                case (init_nst)
                    CKE_WAIT: cnt <= INIT_LAST;
                    MRS_LOAD: cnt <= MRS_LAST;
                    ZQ_CAL:   cnt <= ZQ_LAST;
                    default:  cnt <= '0;
                endcase
                if (init_st == ZQ_CAL) begin
                    running   <= 1'b0;
                    init_done <= 1'b1;
                end
            end else if (running) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // The request drops as soon as power-up is complete
    a_req_dropped: assert property (@(posedge CLK) disable iff (reset)
        init_done |-> !init);

endmodule

// File: timing_signal.sv
`timescale 1ns/1ps

`include "dram_defines.svh"

module timing_signal import dram_pkg::*; (
    input  logic        CLK,
    input  logic        reset,
    input  dram_state_t cmd_st,
    input  dram_state_t cmd_nst,
    input  logic        ram_wait,
    output timing_t     tim,
    output logic        wr_en,
    output logic        rd_en,
    output logic        clear
);

    localparam logic [`REFI_W-1:0] REFI_LAST = `T_REFI - 1;

    logic [`CNT_W-1:0]  cnt;
    logic [`REFI_W-1:0] ref_cnt;
    logic               rf_req;
    logic               ram_wait_q;
    logic               last;

    // Value loaded on entry so that zero marks the final cycle
    function automatic logic [`CNT_W-1:0] state_last(input dram_state_t st);
        case (st)
            PRECHARGE: return `T_RP - 1;
            ACTIVATE:  return `T_RCD - 1;
            READ:      return `T_CL - 1;
            WRITE:     return `T_WR - 1;
            REFRESH:   return `T_RFC - 1;
            default:   return '0;
        endcase
    endfunction

    assign last = (cnt == '0);

    always_ff @(posedge CLK) begin
        if (reset) begin
            cnt        <= '0;
            ref_cnt    <= '0;
            rf_req     <= 1'b0;
            ram_wait_q <= 1'b0;
        end else begin
            ram_wait_q <= ram_wait;
            if (cmd_nst != cmd_st) begin
                cnt <= state_last(cmd_nst);
            end else if (!last) begin
                cnt <= cnt - 1'b1;
            end
            ref_cnt <= (ref_cnt == REFI_LAST) ? '0 : ref_cnt + 1'b1;
            // Refresh request holds until the refresh itself completes
            if (tim.ref_done) begin
                rf_req <= 1'b0;
            end
            if (ref_cnt == REFI_LAST) begin
                rf_req <= 1'b1;
            end
        end
    end

    always_comb begin
        tim.act_done = (cmd_st == ACTIVATE) && last;
        tim.pre_done = (cmd_st == PRECHARGE) && last;
        tim.rd_done  = (cmd_st == READ) && last;
        tim.wr_done  = (cmd_st == WRITE) && last;
        tim.ref_done = (cmd_st == REFRESH) && last;
        tim.rf_req   = rf_req;
    end

    assign rd_en = (cmd_st == READ);
    assign wr_en = (cmd_st == WRITE);
    // Falling edge of ram_wait ends the transfer
    assign clear = ram_wait_q && !ram_wait;

    // A timed state is left exactly in its final counted cycle
    a_leave_on_last: assert property (@(posedge CLK) disable iff (reset)
        (cmd_st inside {PRECHARGE, ACTIVATE, READ, WRITE, REFRESH}) |->
        ((cmd_nst != cmd_st) == last));

endmodule

// File: command_fsm.sv
`timescale 1ns/1ps

`include "dram_defines.svh"

module command_fsm import dram_pkg::*; (
    input  logic        CLK,
    input  logic        reset,
    input  arb_req_t    req,
    input  row_stat_t   row_stat,
    input  timing_t     tim,
    input  logic        init_done,
    output logic        init_req,
    output logic        row_resolve,
    output logic        row_close,
    output logic        ram_wait,
    output dram_state_t cmd_st,
    output dram_state_t cmd_nst
);

    logic req_any;

    assign req_any = req.ren || req.wen;

    always_ff @(posedge CLK) begin
        if (reset) begin
            cmd_st <= IDLE;
        end else begin
            cmd_st <= cmd_nst;
        end
    end

    always_comb begin
        cmd_nst = cmd_st;
        case (cmd_st)
            IDLE: begin
                // Refresh wins over a waiting request
                if (!init_done) begin
                    cmd_nst = IDLE;
                end else if (tim.rf_req) begin
                    cmd_nst = REFRESH;
                end else if (req_any) begin
                    case (row_stat)
                        ROW_CONFLICT: cmd_nst = PRECHARGE;
                        ROW_HIT:      cmd_nst = req.wen ? WRITE : READ;
                        default:      cmd_nst = ACTIVATE;
                    endcase
                end
            end
            PRECHARGE: begin
                if (tim.pre_done) begin
                    cmd_nst = ACTIVATE;
                end
            end
            ACTIVATE: begin
                if (tim.act_done) begin
                    cmd_nst = req.wen ? WRITE : READ;
                end
            end
            READ: begin
                if (tim.rd_done) begin
                    cmd_nst = IDLE;
                end
            end
            WRITE: begin
                if (tim.wr_done) begin
                    cmd_nst = IDLE;
                end
            end
            REFRESH: begin
                if (tim.ref_done) begin
                    cmd_nst = IDLE;
                end
            end
            default: cmd_nst = IDLE;
        endcase
    end

    assign init_req    = (cmd_st == IDLE) && !init_done;
    assign row_resolve = tim.act_done;
    assign row_close   = tim.pre_done;
    // Drops for one cycle as the data burst finishes
    assign ram_wait    = req_any && !(tim.rd_done || tim.wr_done);

    a_no_rd_wr: assert property (@(posedge CLK) disable iff (reset)
        !(req.ren && req.wen));

endmodule

// File: control_unit.sv
`timescale 1ns/1ps

`include "dram_defines.svh"

module control_unit import dram_pkg::*; (
    input  logic      CLK,
    input  logic      reset,
    input  arb_req_t  req,
    output logic      ram_wait,
    output xfer_t     xfer,
    output dram_sig_t sig
);

    dram_addr_t        amap;
    row_stat_t         row_stat;
    logic [`ROW_W-1:0] conflict_row;
    logic              init_req;
    logic              init_done;
    dram_state_t       init_st;
    dram_state_t       init_nst;
    dram_state_t       cmd_st;
    dram_state_t       cmd_nst;
    timing_t           tim;
    logic              row_resolve;
    logic              row_close;
    logic              wr_en;
    logic              rd_en;
    logic              clear;

    addr_mapper u_addr (.addr(req.addr), .amap(amap));

    row_open u_row (
        .CLK(CLK), .reset(reset), .bg(amap.bg), .bank(amap.bank), .row(amap.row),
        .req_en(req.ren || req.wen), .row_resolve(row_resolve), .row_close(row_close),
        .refresh(tim.ref_done), .row_stat(row_stat), .conflict_row(conflict_row)
    );

    init_state u_init (
        .CLK(CLK), .reset(reset), .init(init_req), .init_done(init_done),
        .init_st(init_st), .init_nst(init_nst)
    );

    command_fsm u_cmd (
        .CLK(CLK), .reset(reset), .req(req), .row_stat(row_stat), .tim(tim),
        .init_done(init_done), .init_req(init_req), .row_resolve(row_resolve),
        .row_close(row_close), .ram_wait(ram_wait), .cmd_st(cmd_st), .cmd_nst(cmd_nst)
    );

    timing_signal u_tim (
        .CLK(CLK), .reset(reset), .cmd_st(cmd_st), .cmd_nst(cmd_nst), .ram_wait(ram_wait),
        .tim(tim), .wr_en(wr_en), .rd_en(rd_en), .clear(clear)
    );

    always_comb begin
        xfer.wr_en  = wr_en;
        xfer.rd_en  = rd_en;
        xfer.clear  = clear;
        xfer.offset = amap.offset;
    end

    // Init sequencer owns the state lines until power-up completes
    always_comb begin
        sig.state  = init_done ? cmd_st : init_st;
        sig.nstate = init_done ? cmd_nst : init_nst;
        sig.rank   = amap.rank;
        sig.bg     = amap.bg;
        sig.bank   = amap.bank;
        sig.col    = {amap.col, amap.offset};
        sig.rf_req = tim.rf_req;
        // Precharge needs the row that is open, not the requested one
        sig.row    = (row_stat == ROW_CONFLICT) ? conflict_row : amap.row;
    end

endmodule

// File: control_unit_tb.sv
`timescale 1ns/1ps

`include "dram_defines.svh"

module control_unit_tb import dram_pkg::*; ();

    // One table row: direction, address, expected class and path length
    typedef struct packed {
        logic        wr;
        logic [31:0] addr;
        row_stat_t   cls;
        logic [1:0]  len;
    } entry_t;

    localparam int NUM_ENTRIES = 10;
    localparam int NUM_RANDOM  = 6;

    logic      CLK;
    logic      reset;
    arb_req_t  req;
    logic      ram_wait;
    xfer_t     xfer;
    dram_sig_t sig;

    entry_t      table_q [NUM_ENTRIES];
    logic        model_vld [16];
    logic [14:0] model_row [16];
    logic [31:0] last_addr;
    int          errors;
    int          checks;
    int          tests;
    integer      seed;

    control_unit control_unit_i (
        .CLK(CLK), .reset(reset), .req(req), .ram_wait(ram_wait), .xfer(xfer), .sig(sig)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("FAIL: see errors above");
        $finish;
    endtask

    // x8 layout, top two bits left free
    function automatic logic [31:0] make_addr(input logic rank, input logic [1:0] bg,
                                              input logic [1:0] bank, input logic [14:0] row,
                                              input logic [6:0] col, input logic [2:0] off);
        return {2'b00, rank, row, bg, bank, col, off};
    endfunction

    task automatic clear_model();
        for (int b = 0; b < 16; b++) begin
            model_vld[b] = 1'b0;
        end
    endtask

    task automatic load_table();
        table_q[0] = '{1'b0, make_addr(0, 1, 2, 15'h0123, 7'd5, 3'd3), ROW_CLOSED, 2'd2};
        table_q[1] = '{1'b0, make_addr(0, 1, 2, 15'h0123, 7'd9, 3'd1), ROW_HIT, 2'd1};
        table_q[2] = '{1'b1, make_addr(0, 1, 2, 15'h0123, 7'h7f, 3'd7), ROW_HIT, 2'd1};
        table_q[3] = '{1'b1, make_addr(0, 1, 2, 15'h4abc, 7'd0, 3'd0), ROW_CONFLICT, 2'd3};
        table_q[4] = '{1'b0, make_addr(0, 1, 2, 15'h4abc, 7'd2, 3'd4), ROW_HIT, 2'd1};
        table_q[5] = '{1'b0, make_addr(1, 3, 0, 15'h7fff, 7'd64, 3'd2), ROW_CLOSED, 2'd2};
        table_q[6] = '{1'b1, make_addr(0, 0, 0, 15'h0000, 7'd1, 3'd5), ROW_CLOSED, 2'd2};
        table_q[7] = '{1'b1, make_addr(0, 0, 0, 15'h0001, 7'd3, 3'd6), ROW_CONFLICT, 2'd3};
        // Rank is not part of the bank index
        table_q[8] = '{1'b0, make_addr(0, 3, 0, 15'h7fff, 7'd8, 3'd0), ROW_HIT, 2'd1};
        table_q[9] = '{1'b0, make_addr(0, 1, 2, 15'h4abc, 7'd4, 3'd1) | 32'hc000_0000,
                       ROW_HIT, 2'd1};
    endtask

    // Holds one request until ram_wait falls and checks every cycle of it
    task automatic run_access(input logic wr, input logic [31:0] addr, input row_stat_t tbl_cls,
                              input int tbl_len, input logic use_tbl, input string name);
        int          idx;
        int          cycles;
        int          path_len;
        int          exp_len;
        int          exp_cycles;
        int          err0;
        logic        refreshed;
        logic        saw_pre;
        logic        saw_act;
        logic        in_cmd;
        dram_state_t prev;
        dram_state_t prev_nst;
        row_stat_t   exp_cls;
        row_stat_t   obs_cls;
        logic [14:0] open_before;

        err0 = errors;
        idx = addr[13:10];
        open_before = model_row[idx];
        if (!model_vld[idx]) begin
            exp_cls = ROW_CLOSED;
        end else begin
            exp_cls = (model_row[idx] == addr[28:14]) ? ROW_HIT : ROW_CONFLICT;
        end
        cycles = 0;
        path_len = 0;
        refreshed = 1'b0;
        saw_pre = 1'b0;
        saw_act = 1'b0;
        prev = IDLE;
        prev_nst = IDLE;
        @(posedge CLK);
        req.ren  <= !wr;
        req.wen  <= wr;
        req.addr <= addr;
        do begin
            @(negedge CLK);
            cycles++;
            if (cycles > 50) abort_on_timeout("ram_wait to fall");
            if (cycles > 1) begin
                check(sig.state, prev_nst, "state follows previous next state");
            end
            if (sig.state == REFRESH && !refreshed) begin
                refreshed = 1'b1;
                clear_model();
                exp_cls = ROW_CLOSED;
            end
            in_cmd = (sig.state == PRECHARGE) || (sig.state == ACTIVATE) ||
                     (sig.state == READ) || (sig.state == WRITE);
            if (in_cmd && sig.state != prev) path_len++;
            if (sig.state == PRECHARGE) begin
                saw_pre = 1'b1;
                check(sig.row, open_before, "row during precharge");
            end else if (in_cmd) begin
                check(sig.row, addr[28:14], "row after precharge");
            end
            if (sig.state == ACTIVATE) saw_act = 1'b1;
            check(sig.rank, addr[29], "mapped rank");
            check(sig.bg, addr[13:12], "mapped bank group");
            check(sig.bank, addr[11:10], "mapped bank");
            check(sig.col, addr[9:0], "mapped column with offset");
            check(xfer.offset, addr[2:0], "transfer offset");
            check(xfer.rd_en, sig.state == READ, "rd_en follows READ");
            check(xfer.wr_en, sig.state == WRITE, "wr_en follows WRITE");
            check(xfer.clear, !ram_wait, "clear on ram_wait fall");
            prev = sig.state;
            prev_nst = sig.nstate;
        end while (ram_wait);
        exp_len = (exp_cls == ROW_HIT) ? 1 : (exp_cls == ROW_CLOSED) ? 2 : 3;
        exp_cycles = 1 + (wr ? `T_WR : `T_CL);
        if (exp_cls == ROW_CONFLICT) exp_cycles += `T_RP;
        if (exp_cls != ROW_HIT) exp_cycles += `T_RCD;
        if (refreshed) exp_cycles += `T_RFC + 1;
        obs_cls = saw_pre ? ROW_CONFLICT : (saw_act ? ROW_CLOSED : ROW_HIT);
        check(sig.state, wr ? WRITE : READ, "final data state");
        check(sig.nstate, IDLE, "next state after data burst");
        check(path_len, exp_len, "command states passed");
        check(saw_pre, exp_cls == ROW_CONFLICT, "precharge seen");
        check(saw_act, exp_cls != ROW_HIT, "activate seen");
        check(cycles, exp_cycles, "cycles until ram_wait falls");
        if (use_tbl && !refreshed) begin
            check(obs_cls, tbl_cls, "observed class against table");
            check(path_len, tbl_len, "path length against table");
        end
        model_vld[idx] = 1'b1;
        model_row[idx] = addr[28:14];
        last_addr = addr;
        tests++;
        $display("%s: %s", name, (errors == err0) ? "ok" : "FAILED");
    endtask

    initial begin
        dram_state_t init_seq [4];
        int          init_len [4];
        int          n;
        int          err0;
        logic [31:0] rnd;

        reset = 1'b1;
        req = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        seed = 32'he728_1c1b;
        init_seq = '{POWER_UP, CKE_WAIT, MRS_LOAD, ZQ_CAL};
        init_len = '{1 + `T_INIT, `T_INIT, `T_MRS, `T_ZQ};
        clear_model();
        load_table();

        // Reset values
        err0 = errors;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        check(ram_wait, 1'b0, "ram_wait in reset");
        check({xfer.wr_en, xfer.rd_en, xfer.clear}, 3'b000, "strobes in reset");
        check(sig.rf_req, 1'b0, "rf_req in reset");
        check(sig.state, POWER_UP, "state in reset");
        @(posedge CLK);
        reset <= 1'b0;
        tests++;
        $display("reset: %s", (errors == err0) ? "ok" : "FAILED");

        // Power-up steps in order, one cycle to start plus the step lengths
        err0 = errors;
        @(negedge CLK);
        for (int s = 0; s < 4; s++) begin
            n = 0;
            while (sig.state == init_seq[s]) begin
                if (n > 20) abort_on_timeout("power-up step to end");
                n++;
                @(negedge CLK);
            end
            check(n, init_len[s], "power-up step length");
        end
        check(sig.state, IDLE, "state after power-up");
        tests++;
        $display("init: %s", (errors == err0) ? "ok" : "FAILED");

        for (int t = 0; t < NUM_ENTRIES; t++) begin
            run_access(table_q[t].wr, table_q[t].addr, table_q[t].cls, table_q[t].len, 1'b1,
                       $sformatf("table %0d", t));
        end

        for (int r = 0; r < NUM_RANDOM; r++) begin
            rnd = $random(seed);
            run_access(rnd[31], $random(seed), ROW_CLOSED, 0, 1'b0,
                       $sformatf("random %0d", r));
        end

        // Idle long enough for a refresh, then reuse an open row
        err0 = errors;
        @(posedge CLK);
        req.ren <= 1'b0;
        req.wen <= 1'b0;
        n = 0;
        @(negedge CLK);
        while (!sig.rf_req) begin
            if (n > 2 * `T_REFI) abort_on_timeout("refresh request");
            n++;
            @(negedge CLK);
        end
        n = 0;
        while (sig.state != REFRESH) begin
            if (n > 4) abort_on_timeout("REFRESH state");
            n++;
            @(negedge CLK);
        end
        n = 0;
        while (sig.state == REFRESH) begin
            if (n > `T_RFC + 2) abort_on_timeout("refresh to finish");
            check(sig.rf_req, 1'b1, "rf_req held through refresh");
            n++;
            @(negedge CLK);
        end
        check(n, `T_RFC, "refresh length");
        check(sig.rf_req, 1'b0, "rf_req after refresh");
        clear_model();
        tests++;
        $display("refresh: %s", (errors == err0) ? "ok" : "FAILED");
        run_access(1'b0, last_addr, ROW_CLOSED, 2, 1'b1, "after refresh");

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: control_unit.f
+incdir+.
dram_pkg.sv
addr_mapper.sv
row_open.sv
init_state.sv
timing_signal.sv
command_fsm.sv
control_unit.sv
control_unit_tb.sv
